// ==== common/scan_pkg.sv ====
package scan_pkg;

  //////////////////////////////////////////////////////////////////////
  // Chain and timing constants
  //////////////////////////////////////////////////////////////////////

  localparam int scan_chain_len     = 78;   // Configuration bits in the chip chain.
  localparam int scan_word_count    = 3;    // 32-bit words in the image.
  localparam int scan_image_width   = 96;   // Bits 78 and up never reach the chip.
  localparam int scan_clk_div       = 4;    // Clock cycles per scan tick.
  localparam int scan_div_width     = $clog2(scan_clk_div);
  localparam int scan_bit_cnt_width = 7;

  //////////////////////////////////////////////////////////////////////
  // Host command and response types
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    op_write_word = 2'd0,
    op_scan       = 2'd1,
    op_status     = 2'd2
  } scan_op_e;

  typedef struct packed {
    scan_op_e    op;
    logic [1:0]  index;   // Image word to write.
    logic [31:0] data;
  } scan_cmd_t;

  typedef struct packed {
    scan_op_e    op;
    logic        error;
    logic [31:0] data;
  } scan_resp_t;

  // Decoder to response generator.
  typedef struct packed {
    scan_op_e    op;
    logic        error;
    logic [31:0] word;    // Written word, zero for scan and status.
  } scan_resp_req_t;

  //////////////////////////////////////////////////////////////////////
  // Shifter states
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    idle     = 2'd0,
    shifting = 2'd1,
    loading  = 2'd2
  } shift_state_e;

endpackage

// ==== scan_engine/scan_shifter.sv ====
`timescale 1ns/100ps

module scan_shifter (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  scan_valid,
  output logic                                  scan_ready,
  input  logic [scan_pkg::scan_image_width-1:0] image,
  output logic                                  scan_done,
  output logic                                  scan_id,
  output logic                                  scan_phi,
  output logic                                  scan_phi_bar,
  output logic                                  scan_data_in,
  output logic                                  scan_load_chip
);

  import scan_pkg::*;

  shift_state_e                  state;
  logic [scan_div_width-1:0]     div_cnt;
  logic                          tick;
  logic                          scan_fire;
  logic [1:0]                    phase;
  logic [scan_bit_cnt_width-1:0] bit_cnt;
  logic [scan_chain_len-1:0]     chain_q;
  logic                          in_chain;
  logic                          last_bit;

  assign scan_ready = (state == idle);
  assign scan_fire  = scan_valid && scan_ready;

  //////////////////////////////////////////////////////////////////////
  // Tick divider
  //////////////////////////////////////////////////////////////////////

  // The divider never stops, so the first tick after a launch lands
  // anywhere from one to scan_clk_div cycles later.
  assign tick = (div_cnt == scan_div_width'(scan_clk_div - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      div_cnt <= '0;
    end else if (tick) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Phase and bit counters
  //////////////////////////////////////////////////////////////////////

  // A launch parks the counters one tick before bit 0, phase 0.
  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= 2'd0;
    end else if (scan_fire) begin
      phase <= 2'd3;
    end else if (tick && state != idle) begin
      phase <= phase + 2'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      bit_cnt <= '1;
    end else if (scan_fire) begin
      bit_cnt <= '1;                          // Wraps to bit 0 on the first tick.
    end else if (tick && state != idle && phase == 2'd3) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  assign last_bit = (bit_cnt == scan_bit_cnt_width'(scan_chain_len - 1));

  //////////////////////////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= idle;
      scan_done <= 1'b0;
    end else begin
      scan_done <= 1'b0;
      case (state)
        idle: begin
          if (scan_fire) begin
            state <= shifting;
          end
        end
        shifting: begin
          if (tick && phase == 2'd3 && last_bit) begin
            state <= loading;                 // One extra period for the load pulse.
          end
        end
        loading: begin
          if (tick && phase == 2'd3) begin
            state     <= idle;
            scan_done <= 1'b1;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // Only the chain bits are kept, the upper image bits are never shifted.
  always_ff @(posedge clk) begin
    if (scan_fire) begin
      chain_q <= image[scan_chain_len-1:0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Chip pins
  //////////////////////////////////////////////////////////////////////

  // Before the first tick bit_cnt still holds all ones, which keeps
  // every pin low.
  assign in_chain = (state == shifting) &&
                    (bit_cnt < scan_bit_cnt_width'(scan_chain_len));

  assign scan_id        = (state != idle) &&
                          (bit_cnt <= scan_bit_cnt_width'(scan_chain_len));
  assign scan_phi       = in_chain && (phase == 2'd0);
  assign scan_phi_bar   = in_chain && (phase == 2'd2);
  assign scan_data_in   = in_chain ? chain_q[bit_cnt] : 1'b0;
  assign scan_load_chip = (state == loading) && (phase == 2'd3);

endmodule

// ==== logic/scan_cmd_decode.sv ====
`timescale 1ns/100ps

module scan_cmd_decode (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  cmd_valid,
  input  scan_pkg::scan_cmd_t                   cmd,
  output logic                                  cmd_ready,
  output logic                                  scan_valid,
  input  logic                                  scan_ready,
  output logic [scan_pkg::scan_image_width-1:0] image,
  input  logic                                  scan_done,
  output logic                                  req_valid,
  input  logic                                  req_ready,
  output scan_pkg::scan_resp_req_t              req
);

  import scan_pkg::*;

  typedef enum logic [1:0] {
    dec_idle = 2'd0,
    dec_req  = 2'd1,   // Request waiting for the response generator.
    dec_scan = 2'd2    // Scan launched, waiting for scan_done.
  } dec_state_e;

  dec_state_e state;
  dec_state_e state_next;
  logic       cmd_fire;
  logic       req_fire;
  logic       index_ok;

  assign cmd_fire = cmd_valid && cmd_ready;
  assign req_fire = req_valid && req_ready;
  assign index_ok = (cmd.index < scan_word_count);

  always_comb begin
    state_next = state;
    case (state)
      dec_idle: begin
        if (cmd_fire) begin
          state_next = (cmd.op == op_scan) ? dec_scan : dec_req;
        end
      end
      dec_req: begin
        if (req_fire) begin
          state_next = dec_idle;
        end
      end
      dec_scan: begin
        if (scan_done) begin
          state_next = dec_req;
        end
      end
      default: begin
        state_next = dec_idle;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Control and image
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= dec_idle;
      cmd_ready  <= 1'b0;
      scan_valid <= 1'b0;
      req_valid  <= 1'b0;
      image      <= '0;
    end else begin
      state     <= state_next;
      cmd_ready <= (state_next == dec_idle);   // Busy until the request drains.
      if (scan_valid && scan_ready) begin
        scan_valid <= 1'b0;
      end
      if (req_fire) begin
        req_valid <= 1'b0;
      end
      if (cmd_fire) begin
        case (cmd.op)
          op_write_word: begin
            if (index_ok) begin
              image[{cmd.index, 5'd0} +: 32] <= cmd.data;
            end
            req_valid <= 1'b1;
          end
          op_scan: begin
            scan_valid <= 1'b1;   // The image stays put, no command is taken.
          end
          default: begin
            req_valid <= 1'b1;
          end
        endcase
      end
      if (scan_done && state == dec_scan) begin
        req_valid <= 1'b1;
      end
    end
  end

  // Request payload, held from the command until its transfer.
  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      req.op   <= cmd.op;
      req.word <= (cmd.op == op_write_word) ? cmd.data : 32'd0;
      case (cmd.op)
        op_write_word:      req.error <= !index_ok;
        op_scan, op_status: req.error <= 1'b0;
        default:            req.error <= 1'b1;
      endcase
    end
  end

endmodule

// ==== logic/scan_resp_gen.sv ====
`timescale 1ns/100ps

module scan_resp_gen (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req_valid,
  output logic                     req_ready,
  input  scan_pkg::scan_resp_req_t req,
  output logic                     resp_valid,
  input  logic                     resp_ready,
  output scan_pkg::scan_resp_t     resp
);

  import scan_pkg::*;

  logic [15:0] scan_count;
  logic [15:0] count_next;
  logic        req_fire;

  // A new request is taken only once the held response has left.
  assign req_ready  = !resp_valid || resp_ready;
  assign req_fire   = req_valid && req_ready;
  assign count_next = scan_count + 16'd1;

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_valid <= 1'b0;
      scan_count <= 16'd0;
    end else begin
      if (req_fire) begin
        resp_valid <= 1'b1;
      end else if (resp_ready) begin
        resp_valid <= 1'b0;
      end
      if (req_fire && req.op == op_scan) begin
        scan_count <= count_next;   // Counts completed scans.
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Response payload
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (req_fire) begin
      resp.op    <= req.op;
      resp.error <= req.error;
      case (req.op)
        op_write_word: begin
          resp.data <= req.word;
        end
        op_scan: begin
          resp.data <= {16'd0, count_next};   // Count including this scan.
        end
        op_status: begin
          resp.data <= {16'd0, scan_count};
        end
        default: begin
          resp.data <= 32'd0;
        end
      endcase
    end
  end

endmodule

// ==== logic/scan_config_top.sv ====
`timescale 1ns/100ps

module scan_config_top (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 cmd_valid,
  output logic                 cmd_ready,
  input  scan_pkg::scan_cmd_t  cmd,
  output logic                 resp_valid,
  input  logic                 resp_ready,
  output scan_pkg::scan_resp_t resp,
  output logic                 scan_id,
  output logic                 scan_phi,
  output logic                 scan_phi_bar,
  output logic                 scan_data_in,
  output logic                 scan_load_chip
);

  import scan_pkg::*;

  logic                        scan_valid;
  logic                        scan_ready;
  logic                        scan_done;
  logic [scan_image_width-1:0] image;
  logic                        req_valid;
  logic                        req_ready;
  scan_resp_req_t              req;

  //////////////////////////////////////////////////////////////////////
  // Decode, scan and response
  //////////////////////////////////////////////////////////////////////

  scan_cmd_decode decode_i (
    .clk        (clk),
    .reset      (reset),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .cmd_ready  (cmd_ready),
    .scan_valid (scan_valid),
    .scan_ready (scan_ready),
    .image      (image),
    .scan_done  (scan_done),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req        (req)
  );

  scan_shifter shifter_i (
    .clk            (clk),
    .reset          (reset),
    .scan_valid     (scan_valid),
    .scan_ready     (scan_ready),
    .image          (image),
    .scan_done      (scan_done),
    .scan_id        (scan_id),
    .scan_phi       (scan_phi),
    .scan_phi_bar   (scan_phi_bar),
    .scan_data_in   (scan_data_in),
    .scan_load_chip (scan_load_chip)
  );

  scan_resp_gen resp_i (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req        (req),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp       (resp)
  );

endmodule

// ==== verification/scan_config_checker.sv ====
`timescale 1ns/100ps

module scan_config_checker (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 cmd_valid,
  input  logic                 cmd_ready,
  input  scan_pkg::scan_cmd_t  cmd,
  input  scan_pkg::scan_resp_t exp_resp,
  input  logic                 resp_valid,
  input  logic                 resp_ready,
  input  scan_pkg::scan_resp_t resp,
  input  logic                 scan_id,
  input  logic                 scan_phi,
  input  logic                 scan_phi_bar,
  input  logic                 scan_data_in,
  input  logic                 scan_load_chip,
  input  int                   total,
  output int                   errors,
  output int                   done_count
);

  import scan_pkg::*;

  logic [scan_image_width-1:0] model_image;
  logic [scan_chain_len-1:0]   snap;          // Chain bits as they stood at the scan command.
  scan_resp_t                  exp_q [$];
  scan_resp_t                  want;
  int                          bit_idx;
  int                          bar_idx;
  int                          load_cnt;
  int                          scan_seen;
  int                          err_mark;
  logic                        phi_q;
  logic                        bar_q;
  logic                        load_q;

  function automatic string op_text(input scan_op_e op);
    case (op)
      op_write_word: return "write";
      op_scan:       return "scan";
      op_status:     return "status";
      default:       return "unknown";
    endcase
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
    if (got !== expected) begin
      $display("Error: %s got %h expected %h", name, got, expected);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Pin rules and bitstream capture
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (reset) begin
      model_image = '0;
      snap        = '0;
      bit_idx     = 0;
      bar_idx     = 0;
      load_cnt    = 0;
      scan_seen   = 0;
      err_mark    = 0;
      errors      = 0;
      done_count  = 0;
      phi_q       = 1'b0;
      bar_q       = 1'b0;
      load_q      = 1'b0;
      exp_q.delete();
    end else begin
      if (scan_phi && scan_phi_bar) begin
        $display("scan_phi and scan_phi_bar are high together.");
        errors++;
      end
      if ((scan_phi || scan_phi_bar) && (scan_load_chip || !scan_id)) begin
        $display("A scan clock phase is high during the load or outside scan_id.");
        errors++;
      end
      if (scan_load_chip && !scan_id) begin
        $display("scan_load_chip is high outside scan_id.");
        errors++;
      end
      if (scan_phi && !phi_q) begin
        if (load_cnt != 0 || bit_idx >= scan_chain_len) begin
          $display("Extra scan_phi pulse after the last chain bit.");
          errors++;
        end else if (scan_data_in !== snap[bit_idx]) begin
          $display("Error: scan_data_in bit %0d got %h expected %h",
                   bit_idx, scan_data_in, snap[bit_idx]);
          errors++;
        end
        bit_idx++;
      end
      if (scan_phi_bar && !bar_q) begin
        if (bar_idx + 1 != bit_idx) begin
          $display("scan_phi_bar pulsed without a matching scan_phi pulse.");
          errors++;
        end
        bar_idx++;
      end
      if (scan_load_chip && !load_q) begin
        if (bit_idx != scan_chain_len) begin
          $display("scan_load_chip pulsed after %0d bits instead of 78.", bit_idx);
          errors++;
        end
        load_cnt++;
      end
      phi_q  = scan_phi;
      bar_q  = scan_phi_bar;
      load_q = scan_load_chip;

      if (cmd_valid && cmd_ready) begin
        if (scan_id) begin
          $display("scan_id is high while the controller takes a command.");
          errors++;
        end
        exp_q.push_back(exp_resp);
        if (cmd.op == op_write_word && cmd.index < 2'd3) begin
          model_image[32 * cmd.index +: 32] = cmd.data;
        end
        if (cmd.op == op_scan) begin
          snap     = model_image[scan_chain_len-1:0];
          bit_idx  = 0;
          bar_idx  = 0;
          load_cnt = 0;
        end
      end

      if (resp_valid && resp_ready) begin
        if (exp_q.size() == 0) begin
          $display("A response arrived with no command outstanding.");
          errors++;
        end else begin
          want = exp_q.pop_front();
          compare_value("resp.op", 32'(resp.op), 32'(want.op));
          compare_value("resp.error", 32'(resp.error), 32'(want.error));
          compare_value("resp.data", resp.data, want.data);
          if (want.op == op_scan) begin
            scan_seen++;
            compare_value("scan count", resp.data, 32'(scan_seen));
            if (bit_idx != scan_chain_len || load_cnt != 1) begin
              $display("The scan shifted %0d bits with %0d load pulses.", bit_idx, load_cnt);
              errors++;
            end
            if (bar_idx != scan_chain_len) begin
              $display("The scan gave %0d scan_phi_bar pulses instead of 78.", bar_idx);
              errors++;
            end
          end else if (want.op == op_status) begin
            compare_value("status count", resp.data, 32'(scan_seen));
          end
          done_count++;
          $display("test %0d %s: %s", done_count, op_text(want.op),
                   (errors == err_mark) ? "ok" : "mismatch");
          err_mark = errors;
          if (done_count == total) begin
            $display("%0d tests run, %0d errors", done_count, errors);
          end
        end
      end
    end
  end

endmodule

// ==== verification/scan_config_tb.sv ====
`timescale 1ns/100ps

module scan_config_tb;

  import scan_pkg::*;

  localparam int num_tests = 11;
  localparam int wd_cycles = num_tests * (1264 + 50);

  logic        clk;
  logic        reset;
  logic        cmd_valid;
  logic        cmd_ready;
  scan_cmd_t   cmd;
  scan_resp_t  exp_resp;
  logic        resp_valid;
  logic        resp_ready = 1'b0;
  scan_resp_t  resp;
  logic        scan_id;
  logic        scan_phi;
  logic        scan_phi_bar;
  logic        scan_data_in;
  logic        scan_load_chip;
  logic [31:0] rnd_state = 32'd59680;
  int          errors;
  int          done_count;
  int          n_entries = 0;
  int          test_idx;
  scan_cmd_t   tbl_cmd [num_tests];
  scan_resp_t  tbl_resp [num_tests];

  scan_config_top dut_i (
    .clk            (clk),
    .reset          (reset),
    .cmd_valid      (cmd_valid),
    .cmd_ready      (cmd_ready),
    .cmd            (cmd),
    .resp_valid     (resp_valid),
    .resp_ready     (resp_ready),
    .resp           (resp),
    .scan_id        (scan_id),
    .scan_phi       (scan_phi),
    .scan_phi_bar   (scan_phi_bar),
    .scan_data_in   (scan_data_in),
    .scan_load_chip (scan_load_chip)
  );

  scan_config_checker checker_i (
    .clk            (clk),
    .reset          (reset),
    .cmd_valid      (cmd_valid),
    .cmd_ready      (cmd_ready),
    .cmd            (cmd),
    .exp_resp       (exp_resp),
    .resp_valid     (resp_valid),
    .resp_ready     (resp_ready),
    .resp           (resp),
    .scan_id        (scan_id),
    .scan_phi       (scan_phi),
    .scan_phi_bar   (scan_phi_bar),
    .scan_data_in   (scan_data_in),
    .scan_load_chip (scan_load_chip),
    .total          (num_tests),
    .errors         (errors),
    .done_count     (done_count)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  task automatic add_entry(input scan_op_e cmd_op, input logic [1:0] cmd_index,
                           input logic [31:0] cmd_data, input logic exp_error,
                           input logic [31:0] exp_data);
    tbl_cmd[n_entries].op     = cmd_op;
    tbl_cmd[n_entries].index  = cmd_index;
    tbl_cmd[n_entries].data   = cmd_data;
    tbl_resp[n_entries].op    = cmd_op;
    tbl_resp[n_entries].error = exp_error;
    tbl_resp[n_entries].data  = exp_data;
    n_entries++;
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // The host accepts a response about three cycles in four.
  always @(posedge clk) begin
    rnd_state  <= xorshift32(rnd_state);
    resp_ready <= !reset && (rnd_state[1:0] != 2'b00);
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus table and drive loop
  //////////////////////////////////////////////////////////////////////

  initial begin
    reset     = 1'b1;
    cmd_valid = 1'b0;
    cmd       = '0;
    exp_resp  = '0;
    add_entry(op_write_word, 2'd0, 32'ha5c3_0f1e, 1'b0, 32'ha5c3_0f1e);
    add_entry(op_write_word, 2'd1, 32'h1234_5678, 1'b0, 32'h1234_5678);
    add_entry(op_write_word, 2'd2, 32'hdead_beef, 1'b0, 32'hdead_beef);
    add_entry(op_status,     2'd0, 32'h0,         1'b0, 32'd0);
    add_entry(op_scan,       2'd0, 32'h0,         1'b0, 32'd1);
    add_entry(op_write_word, 2'd3, 32'hffff_ffff, 1'b1, 32'hffff_ffff);  // Bad index.
    add_entry(op_scan,       2'd0, 32'h0,         1'b0, 32'd2);
    add_entry(op_write_word, 2'd0, 32'h0f0f_00ff, 1'b0, 32'h0f0f_00ff);
    add_entry(op_status,     2'd0, 32'h0,         1'b0, 32'd2);
    add_entry(op_scan,       2'd0, 32'h0,         1'b0, 32'd3);
    add_entry(op_status,     2'd0, 32'h0,         1'b0, 32'd3);
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    for (test_idx = 0; test_idx < num_tests; test_idx++) begin
      cmd_valid <= 1'b1;
      cmd       <= tbl_cmd[test_idx];
      exp_resp  <= tbl_resp[test_idx];
      do begin
        @(posedge clk);
      end while (!cmd_ready);
    end
    cmd_valid <= 1'b0;
    while (done_count != num_tests) begin
      @(negedge clk);
    end
    @(negedge clk);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    repeat (wd_cycles) @(posedge clk);
    $display("Watchdog expired with %0d of %0d responses seen.", done_count, num_tests);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== vlog.f ====
common/scan_pkg.sv
scan_engine/scan_shifter.sv
logic/scan_cmd_decode.sv
logic/scan_resp_gen.sv
logic/scan_config_top.sv
verification/scan_config_checker.sv
verification/scan_config_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output.
verilator --binary --timing -Wno-fatal -f vlog.f --top-module scan_config_tb \
  -o scan_config_sim &&
  out=$(./obj_dir/scan_config_sim) &&
  echo "$out" &&
  echo "$out" | grep -qF '*** PASSED ***' ||
  exit 1
